// File: build.f
plru_pkg.sv
hit_encoder.sv
plru_tree.sv
refill_select.sv
utlb_plru.sv
tb_utlb_plru.sv

// File: run.sh
#!/bin/sh
# Build and run the micro-TLB pseudo-LRU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f build.f \
  --top-module tb_utlb_plru \
  -o sim_utlb_plru

output=$(./obj_dir/sim_utlb_plru) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "STATUS: PASS"; then
  exit 0
else
  exit 1
fi

// File: tb_utlb_plru.sv
// Testbench for the micro-TLB pseudo-LRU replacement logic
// Applies a table of hit and refill rows, one per clock, and checks ref_num
// against a behavioral model of the tree, hit filter and refill register
module tb_utlb_plru;

  // Reset plus about 30 rows, with ample margin
  localparam int CYCLE_LIMIT = 200;

  typedef struct packed {
    plru_pkg::entry_mask_t vld;
    logic                  hvld;
    plru_pkg::entry_mask_t hmask;
    logic                  ron;
    logic                  rvld;
    logic                  chk;
  } row_t;

  logic                  lru_clk;
  logic                  cpurst_b;
  plru_pkg::entry_mask_t entry_vld;
  plru_pkg::hit_req_t    read_hit;
  logic                  refill_on;
  logic                  refill_vld;
  plru_pkg::entry_mask_t ref_num;

  row_t                  rows[$];
  integer                seed;
  int                    cycle_cnt = 0;

  // Model state
  plru_pkg::plru_node_t  m_nodes;
  plru_pkg::entry_idx_t  m_last;
  plru_pkg::entry_idx_t  m_reg;
  plru_pkg::entry_mask_t exp_ref_num;

  utlb_plru i_utlb_plru (
    .lru_clk    (lru_clk),
    .cpurst_b   (cpurst_b),
    .entry_vld  (entry_vld),
    .read_hit   (read_hit),
    .refill_on  (refill_on),
    .refill_vld (refill_vld),
    .ref_num    (ref_num)
  );

  always #10 lru_clk = ~lru_clk;

  // --------------------
  // Model helpers
  // --------------------

  function automatic plru_pkg::entry_mask_t one_hot(input plru_pkg::entry_idx_t idx);
    one_hot = plru_pkg::entry_mask_t'(1) << idx;
  endfunction

  // Position of the single set bit, 0 for any other mask
  function automatic plru_pkg::entry_idx_t encode_hit(input plru_pkg::entry_mask_t mask);
    int ones;
    int pos;
    ones = 0;
    pos  = 0;
    for (int i = 0; i < plru_pkg::ENTRY_NUM; i++)
    begin
      if (mask[i])
      begin
        ones++;
        pos = i;
      end
    end
    encode_hit = (ones == 1) ? plru_pkg::entry_idx_t'(pos) : '0;
  endfunction

  // Lowest entry with a clear valid bit, -1 when all are valid
  function automatic int lowest_free(input plru_pkg::entry_mask_t vld);
    for (int i = 0; i < plru_pkg::ENTRY_NUM; i++)
    begin
      if (!vld[i])
        return i;
    end
    return -1;
  endfunction

  // Node at level lvl on a path is (2^lvl - 1) plus the path prefix
  function automatic plru_pkg::entry_idx_t model_victim();
    int prefix;
    prefix = 0;
    for (int lvl = 0; lvl < plru_pkg::IDX_W; lvl++)
      prefix = 2 * prefix + int'(m_nodes[(1 << lvl) - 1 + prefix]);
    model_victim = plru_pkg::entry_idx_t'(prefix);
  endfunction

  task automatic move_away(input plru_pkg::entry_idx_t idx);
    int node;
    for (int lvl = 0; lvl < plru_pkg::IDX_W; lvl++)
    begin
      node = (1 << lvl) - 1 + (int'(idx) >> (plru_pkg::IDX_W - lvl));
      m_nodes[node] = ~idx[plru_pkg::IDX_W-1-lvl];
    end
  endtask

  // State after the next rising edge, given this row's inputs
  task automatic model_step(input row_t row);
    plru_pkg::entry_idx_t victim;
    plru_pkg::entry_idx_t choose;
    plru_pkg::entry_idx_t hit_i;
    int                   free_i;
    logic                 read_upd;
    victim   = model_victim();
    free_i   = lowest_free(row.vld);
    choose   = (free_i < 0) ? victim : plru_pkg::entry_idx_t'(free_i);
    hit_i    = encode_hit(row.hmask);
    read_upd = row.hvld && (hit_i != m_last);
    if (row.rvld)
      move_away(m_reg);
    else if (read_upd)
      move_away(hit_i);
    if (row.hvld)
      m_last = hit_i;
    if (row.ron)
      m_reg = choose;
    exp_ref_num = one_hot(m_reg);
  endtask

  // --------------------
  // Stimulus and checks
  // --------------------

  task automatic add_row(input plru_pkg::entry_mask_t vld, input logic hvld,
                         input plru_pkg::entry_mask_t hmask, input logic ron,
                         input logic rvld, input logic chk);
    row_t row;
    row.vld   = vld;
    row.hvld  = hvld;
    row.hmask = hmask;
    row.ron   = ron;
    row.rvld  = rvld;
    row.chk   = chk;
    rows.push_back(row);
  endtask

  task automatic build_table();
    plru_pkg::entry_mask_t full;
    plru_pkg::entry_mask_t rnd_vld;
    full    = '1;
    rnd_vld = plru_pkg::entry_mask_t'($random(seed)) & 16'hff7f;
    // Reset value, then lowest free entry and hold
    add_row(full, 1'b0, '0, 1'b0, 1'b0, 1'b1);
    add_row(16'hfff3, 1'b0, '0, 1'b1, 1'b0, 1'b1);
    add_row(16'hfff3, 1'b0, '0, 1'b0, 1'b0, 1'b1);
    add_row(rnd_vld, 1'b0, '0, 1'b1, 1'b0, 1'b1);
    add_row(rnd_vld, 1'b0, '0, 1'b0, 1'b0, 1'b1);
    // Victim walk through refill completions
    for (int k = 0; k < 4; k++)
    begin
      add_row(full, 1'b0, '0, 1'b1, 1'b0, 1'b1);
      add_row(full, 1'b0, '0, 1'b0, 1'b1, 1'b1);
    end
    // Repeated hit to entry 5 with a refill between
    add_row(full, 1'b1, one_hot(4'd5), 1'b0, 1'b0, 1'b1);
    add_row(full, 1'b0, '0, 1'b0, 1'b1, 1'b1);
    add_row(full, 1'b1, one_hot(4'd5), 1'b0, 1'b0, 1'b1);
    add_row(full, 1'b0, '0, 1'b1, 1'b0, 1'b1);
    // Random hits steer the victim
    for (int k = 0; k < 3; k++)
      add_row(full, 1'b1, one_hot(plru_pkg::entry_idx_t'($random(seed))), 1'b0, 1'b0, 1'b0);
    add_row(full, 1'b0, '0, 1'b1, 1'b0, 1'b1);
    // Refill completion and fresh hit together
    add_row(full, 1'b1, one_hot(4'd3), 1'b0, 1'b0, 1'b1);
    add_row(full, 1'b1, one_hot(4'd9), 1'b0, 1'b1, 1'b1);
    add_row(full, 1'b0, '0, 1'b1, 1'b0, 1'b1);
    // Malformed hit mask counts as entry 0
    add_row(full, 1'b1, 16'h0006, 1'b0, 1'b0, 1'b1);
    add_row(full, 1'b0, '0, 1'b1, 1'b0, 1'b1);
  endtask

  task automatic apply_row(input row_t row);
    entry_vld     = row.vld;
    read_hit.vld  = row.hvld;
    read_hit.mask = row.hmask;
    refill_on     = row.ron;
    refill_vld    = row.rvld;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("** Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // Run limit
  always @(posedge lru_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT)
    begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("STATUS: FAIL");
      $fatal(1, "timeout");
    end
  end

  initial
  begin
    lru_clk     = 1'b0;
    cpurst_b    = 1'b0;
    entry_vld   = '1;
    read_hit    = '0;
    refill_on   = 1'b0;
    refill_vld  = 1'b0;
    seed        = 32'hffa06e13;
    m_nodes     = '0;
    m_last      = '0;
    m_reg       = '0;
    exp_ref_num = one_hot('0);
    build_table();

    repeat (4) @(posedge lru_clk);
    @(negedge lru_clk);
    cpurst_b = 1'b1;

    // Drive on the falling edge, check on the following falling edge
    foreach (rows[r])
    begin
      apply_row(rows[r]);
      model_step(rows[r]);
      @(negedge lru_clk);
      if (rows[r].chk)
        check_value("ref_num", 32'(ref_num), 32'(exp_ref_num));
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: utlb_plru.sv
// Top level of the micro-TLB pseudo-LRU replacement logic
// Read hits and refill completions update the tree, and ref_num
// names the entry for the next refill
module utlb_plru (
  input  logic                  lru_clk,
  input  logic                  cpurst_b,
  input  plru_pkg::entry_mask_t entry_vld,
  input  plru_pkg::hit_req_t    read_hit,
  input  logic                  refill_on,
  input  logic                  refill_vld,
  output plru_pkg::entry_mask_t ref_num
);

  plru_pkg::tree_access_t read_access;
  plru_pkg::tree_access_t fill_access;
  plru_pkg::entry_idx_t   victim_idx;

  // --------------------
  // Hit path
  // --------------------
  hit_encoder i_hit_encoder (
    .lru_clk     (lru_clk),
    .cpurst_b    (cpurst_b),
    .read_hit    (read_hit),
    .read_access (read_access)
  );

  // --------------------
  // Node state
  // --------------------
  plru_tree i_plru_tree (
    .lru_clk     (lru_clk),
    .cpurst_b    (cpurst_b),
    .read_access (read_access),
    .fill_access (fill_access),
    .victim_idx  (victim_idx)
  );

  // --------------------
  // Refill path
  // --------------------
  refill_select i_refill_select (
    .lru_clk     (lru_clk),
    .cpurst_b    (cpurst_b),
    .entry_vld   (entry_vld),
    .refill_on   (refill_on),
    .refill_vld  (refill_vld),
    .victim_idx  (victim_idx),
    .ref_num     (ref_num),
    .fill_access (fill_access)
  );

endmodule

// File: refill_select.sv
// Refill entry choice for the micro-TLB
// Prefers the lowest invalid entry, otherwise takes the tree victim;
// the choice is held from refill_on until the next one
module refill_select (
  input  logic                   lru_clk,
  input  logic                   cpurst_b,
  input  plru_pkg::entry_mask_t  entry_vld,
  input  logic                   refill_on,
  input  logic                   refill_vld,
  input  plru_pkg::entry_idx_t   victim_idx,
  output plru_pkg::entry_mask_t  ref_num,
  output plru_pkg::tree_access_t fill_access
);

  logic                 all_vld;
  plru_pkg::entry_idx_t free_idx;
  plru_pkg::entry_idx_t choose_idx;
  plru_pkg::entry_idx_t refill_idx;

  // --------------------
  // Entry choice
  // --------------------

  assign all_vld = &entry_vld;

  // Scan downward so the lowest free entry is the last one written
  always_comb
  begin
    free_idx = '0;
    for (int i = plru_pkg::ENTRY_NUM - 1; i >= 0; i--)
    begin
      if (!entry_vld[i])
        free_idx = plru_pkg::entry_idx_t'(i);
    end
  end

  assign choose_idx = all_vld ? victim_idx : free_idx;

  // Held refill number
  always_ff @(posedge lru_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      refill_idx <= '0;
    else if (refill_on)
      refill_idx <= choose_idx;
  end

  // --------------------
  // Outputs
  // --------------------

  // One-hot form for the TLB write select
  always_comb
  begin
    for (int i = 0; i < plru_pkg::ENTRY_NUM; i++)
    begin
      ref_num[i] = (refill_idx == plru_pkg::entry_idx_t'(i));
    end
  end

  // Refill completion moves the tree off the refilled entry
  always_comb
  begin
    fill_access.updt = refill_vld;
    fill_access.idx  = refill_idx;
  end

endmodule

// File: plru_tree.sv
// Tree pseudo-LRU state for the 16-entry micro-TLB
// Holds the 15 node bits, moves the path of an accessed entry away from it
// and walks the tree to name the next victim
module plru_tree (
  input  logic                   lru_clk,
  input  logic                   cpurst_b,
  input  plru_pkg::tree_access_t read_access,
  input  plru_pkg::tree_access_t fill_access,
  output plru_pkg::entry_idx_t   victim_idx
);

  // Heap layout of the node bits
  //
  //              0
  //          /       \
  //         1         2
  //       /   \     /   \
  //      3     4   5     6
  //     / \   / \ / \   / \
  //    7  8  9 10 11 12 13 14
  //
  // Left child is direction 0, right child is direction 1

  plru_pkg::plru_node_t   nodes;
  plru_pkg::plru_node_t   nodes_nxt;
  plru_pkg::tree_access_t win_access;
  logic                   tree_updt;
  int unsigned            updt_pos;
  int unsigned            walk_pos;

  // --------------------
  // Update select
  // --------------------

  // Refill has priority over a read hit in the same cycle
  assign win_access = fill_access.updt ? fill_access : read_access;
  assign tree_updt  = fill_access.updt || read_access.updt;

  // --------------------
  // Path update
  // --------------------

  // One node per level, each set to point away from the accessed entry
  always_comb
  begin
    nodes_nxt = nodes;
    updt_pos  = 0;
    for (int lvl = 0; lvl < plru_pkg::IDX_W; lvl++)
    begin
      nodes_nxt[updt_pos] = ~win_access.idx[plru_pkg::IDX_W-1-lvl];
      updt_pos = 2 * updt_pos + 1 + 32'(win_access.idx[plru_pkg::IDX_W-1-lvl]);
    end
  end

  always_ff @(posedge lru_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      nodes <= '0;
    else if (tree_updt)
      nodes <= nodes_nxt;
  end

  // --------------------
  // Victim walk
  // --------------------

  // Follow each node's bit from the root, MSB of the victim first
  always_comb
  begin
    victim_idx = '0;
    walk_pos   = 0;
    for (int lvl = 0; lvl < plru_pkg::IDX_W; lvl++)
    begin
      victim_idx[plru_pkg::IDX_W-1-lvl] = nodes[walk_pos];
      walk_pos = 2 * walk_pos + 1 + 32'(nodes[walk_pos]);
    end
  end

endmodule

// File: hit_encoder.sv
// Read-hit front end of the pseudo-LRU
// Encodes the one-hot hit into an entry number and drops repeated hits,
// so only a hit to a new entry produces a tree access
module hit_encoder (
  input  logic                   lru_clk,
  input  logic                   cpurst_b,
  input  plru_pkg::hit_req_t     read_hit,
  output plru_pkg::tree_access_t read_access
);

  logic                 mask_onehot;
  plru_pkg::entry_idx_t raw_idx;
  plru_pkg::entry_idx_t hit_idx;
  plru_pkg::entry_idx_t last_hit_idx;

  // --------------------
  // One-hot encode
  // --------------------

  // Exactly one bit set
  assign mask_onehot = (read_hit.mask != '0)
                    && ((read_hit.mask & (read_hit.mask - 1'b1)) == '0);

  // OR of the positions of all set bits
  always_comb
  begin
    raw_idx = '0;
    for (int i = 0; i < plru_pkg::ENTRY_NUM; i++)
    begin
      if (read_hit.mask[i])
      begin
        raw_idx = raw_idx | plru_pkg::entry_idx_t'(i);
      end
    end
  end

  // Malformed masks fall back to entry 0
  assign hit_idx = mask_onehot ? raw_idx : '0;

  // --------------------
  // Repeat filter
  // --------------------

  // Tracks every valid hit, filtered or not
  always_ff @(posedge lru_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      last_hit_idx <= '0;
    else if (read_hit.vld)
      last_hit_idx <= hit_idx;
  end

  always_comb
  begin
    read_access.updt = read_hit.vld && (hit_idx != last_hit_idx);
    read_access.idx  = hit_idx;
  end

endmodule

// File: plru_pkg.sv
// Shared sizes and types for the micro-TLB pseudo-LRU replacement logic
// Every RTL file refers to these by scoped name
package plru_pkg;

  // --------------------
  // Sizes
  // --------------------

  // TLB entries covered by the tree
  localparam int ENTRY_NUM = 16;

  // Bits in an entry number
  localparam int IDX_W     = $clog2(ENTRY_NUM);

  // Internal nodes of a full binary tree over ENTRY_NUM leaves
  localparam int NODE_NUM  = ENTRY_NUM - 1;

  // --------------------
  // Vector types
  // --------------------

  // One bit per entry, used for valid flags, hits and the refill number
  typedef logic [ENTRY_NUM-1:0] entry_mask_t;

  // Encoded entry number
  typedef logic [IDX_W-1:0]     entry_idx_t;

  // Node bits in heap order, node n has children 2n+1 and 2n+2
  typedef logic [NODE_NUM-1:0]  plru_node_t;

  // --------------------
  // Grouped signals
  // --------------------

  // Read hit from the TLB lookup
  typedef struct packed {
    logic        vld;
    entry_mask_t mask;
  } hit_req_t;

  // Request to move the tree away from one entry
  typedef struct packed {
    logic       updt;
    entry_idx_t idx;
  } tree_access_t;

endpackage
